// ==== common/btb_macros.svh ====
/*
 * Geometry of the micro BTB and depth of the return address stack.
 * Included by the packages and by the storage modules that size arrays.
 */
`ifndef BTB_MACROS_SVH
`define BTB_MACROS_SVH

// ------------------------------------------------------------
// Address and fetch block
// ------------------------------------------------------------
`define BTB_XLEN      32    // Instruction address width
`define BTB_FETCH_HW  4     // Halfwords per 8-byte fetch block

// ------------------------------------------------------------
// Buffer and stack sizes
// ------------------------------------------------------------
`define BTB_WAYS      4     // Ways per set, the PLRU tree assumes 4
`define BTB_SETS      16

// Return stack entries, a power of two so the pointer wraps cleanly
`define RAS_DEPTH     8

`endif

// ==== common/branchPkg.sv ====
/*
 * Branch-level types shared by the predictor and its testbench.
 * Refer to them by scoped name, e.g. branchPkg::addrT.
 */
`include "btb_macros.svh"

package branchPkg;

    // Instruction or fetch block address
    typedef logic [`BTB_XLEN-1:0] addrT;

    // Branch kinds recorded in the buffer
    typedef enum logic [2:0] {
        NONE  = 3'd0,   // No branch, nothing stored
        COND  = 3'd1,   // Conditional branch
        JMP   = 3'd2,   // Direct jump
        IJMP  = 3'd3,   // Indirect jump
        CALL  = 3'd4,
        ICALL = 3'd5,   // Indirect call
        RET   = 3'd6    // Return, target comes from the stack
    } branchTypeT;

    // 2-bit saturating counter, high bit means predict taken
    typedef logic [1:0] counterT;

    // Halfword slot of the branch inside the fetch block
    typedef logic [$clog2(`BTB_FETCH_HW)-1:0] hwIndexT;

endpackage

// ==== common/btbPkg.sv ====
/*
 * Buffer-level types: way, set and tag fields, the stored entry and the
 * lookup, prediction and update structs. Also holds the address split.
 */
`include "btb_macros.svh"

package btbPkg;

    // ------------------------------------------------------------
    // Address split: | tag | set | byte offset in block |
    // ------------------------------------------------------------
    localparam int SET_LSB  = $clog2(`BTB_FETCH_HW) + 1;   // Halfwords to bytes
    localparam int SET_BITS = $clog2(`BTB_SETS);
    localparam int TAG_LSB  = SET_LSB + SET_BITS;
    localparam int WAY_BITS = $clog2(`BTB_WAYS);

    typedef logic [WAY_BITS-1:0]          wayT;
    typedef logic [SET_BITS-1:0]          setT;
    typedef logic [`BTB_XLEN-1:TAG_LSB]   tagT;

    typedef struct packed {
        tagT                   tag;
        branchPkg::branchTypeT brType;
        branchPkg::hwIndexT    index;
        branchPkg::addrT       target;   // Unused for RET
        branchPkg::counterT    counter;
    } btbEntryT;

    typedef struct packed {
        branchPkg::addrT fetchAddr;
    } lookupReqT;

    typedef struct packed {
        logic                  hit;
        wayT                   way;
        branchPkg::branchTypeT brType;
        branchPkg::hwIndexT    index;
        logic                  taken;
        branchPkg::addrT       target;
        branchPkg::counterT    counter;
        branchPkg::addrT       rasPeek;  // Top of stack, 0 when empty
    } predictionT;

    typedef struct packed {
        branchPkg::addrT       fetchAddr;
        branchPkg::hwIndexT    index;
        branchPkg::branchTypeT brType;
        logic                  taken;
        branchPkg::addrT       target;
        logic                  prevHit;      // Copied from the earlier prediction
        wayT                   prevWay;
        branchPkg::counterT    prevCounter;
    } updateT;

    function automatic setT setOf(branchPkg::addrT addr);
        return addr[TAG_LSB-1:SET_LSB];
    endfunction

    function automatic tagT tagOf(branchPkg::addrT addr);
        return addr[`BTB_XLEN-1:TAG_LSB];
    endfunction

endpackage

// ==== hw/btb/btbWayArray.sv ====
/*
 * Entry storage for all ways of the micro BTB. One inferred memory per way
 * with a 1-cycle read-first port, a resettable valid bit per entry and the
 * tag compare against the tag registered with the read.
 */
`include "btb_macros.svh"

module btbWayArray (
    input  logic                              clk,
    input  logic                              rst,
    input  btbPkg::setT                       readSet,
    input  btbPkg::tagT                       readTag,
    input  logic [`BTB_WAYS-1:0]              writeEn,
    input  btbPkg::setT                       writeSet,
    input  btbPkg::btbEntryT                  writeEntry,
    output logic [`BTB_WAYS-1:0]              hitWay,
    output btbPkg::btbEntryT [`BTB_WAYS-1:0]  readEntry
);

    btbPkg::tagT tagQ;  // Tag of the set being read, lines up with read data

    always_ff @(posedge clk) begin
        tagQ <= readTag;
    end

    // ------------------------------------------------------------
    // One memory, valid vector and compare per way
    // ------------------------------------------------------------
    for (genvar w = 0; w < `BTB_WAYS; w++) begin : gWay
        btbPkg::btbEntryT      mem [`BTB_SETS];
        btbPkg::btbEntryT      rdQ;
        logic [`BTB_SETS-1:0]  validBits;
        logic                  validQ;

        // Read-first, so a write to the set being read shows next cycle
        always_ff @(posedge clk) begin
            if (writeEn[w]) begin
                mem[writeSet] <= writeEntry;
            end
            rdQ <= mem[readSet];
        end

        // Valid bits live outside the memory so that reset can clear them
        always_ff @(posedge clk) begin
            if (rst) begin
                validBits <= '0;
                validQ    <= 1'b0;
            end else begin
                if (writeEn[w]) begin
                    validBits[writeSet] <= 1'b1;
                end
                validQ <= validBits[readSet];
            end
        end

        assign readEntry[w] = rdQ;
        assign hitWay[w]    = validQ && (rdQ.tag == tagQ);
    end

endmodule

// ==== hw/btb/plruTree.sv ====
/*
 * Tree pseudo-LRU state for a 4-way buffer, 3 bits per set.
 * Lookup hits and writes both touch the tree. The victim is read from the
 * set being written so the update logic can place a new entry.
 */
`include "btb_macros.svh"

module plruTree (
    input  logic         clk,
    input  logic         rst,
    input  logic         readAccess,
    input  btbPkg::setT  readSet,
    input  btbPkg::wayT  readWay,
    input  logic         writeAccess,
    input  btbPkg::setT  writeSet,
    input  btbPkg::wayT  writeWay,
    output btbPkg::wayT  victimWay
);

    // Bit 0 picks the half, bit 1 the way in 0/1, bit 2 the way in 2/3
    logic [2:0] treeBits [`BTB_SETS];
    logic [2:0] victimBits;

    // Point every node on the path away from the accessed way
    function automatic logic [2:0] touch(logic [2:0] bits, btbPkg::wayT way);
        logic [2:0] nextBits;
        nextBits    = bits;
        nextBits[0] = ~way[1];
        if (way[1]) begin
            nextBits[2] = ~way[0];
        end else begin
            nextBits[1] = ~way[0];
        end
        return nextBits;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `BTB_SETS; s++) begin
                treeBits[s] <= '0;
            end
        end else begin
            // A write to the same set takes precedence over the read
            if (readAccess && !(writeAccess && (writeSet == readSet))) begin
                treeBits[readSet] <= touch(treeBits[readSet], readWay);
            end
            if (writeAccess) begin
                treeBits[writeSet] <= touch(treeBits[writeSet], writeWay);
            end
        end
    end

    assign victimBits = treeBits[writeSet];
    assign victimWay  = victimBits[0] ? {1'b1, victimBits[2]} : {1'b0, victimBits[1]};

endmodule

// ==== hw/ras/returnStack.sv ====
/*
 * Circular return address stack. Push and pop act at the clock edge and
 * peek/empty reflect the new state in the following cycle. A push on a
 * full stack overwrites the oldest entry.
 */
`include "btb_macros.svh"

module returnStack (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  branchPkg::addrT  pushAddr,
    input  logic             pop,
    output branchPkg::addrT  peek,
    output logic             empty
);

    localparam int PTR_W = $clog2(`RAS_DEPTH);
    localparam int CNT_W = $clog2(`RAS_DEPTH + 1);

    branchPkg::addrT   mem [`RAS_DEPTH];
    logic [PTR_W-1:0]  topPtr;     // Slot of the most recent push
    logic [PTR_W-1:0]  pushPtr;
    logic [CNT_W-1:0]  count;      // Live entries, saturates at depth

    assign pushPtr = topPtr + 1'b1;

    // ------------------------------------------------------------
    // Pointer and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            topPtr <= '0;
            count  <= '0;
        end else if (push) begin
            topPtr <= pushPtr;
            if (count != CNT_W'(`RAS_DEPTH)) begin
                count <= count + 1'b1;
            end
        end else if (pop) begin
            // Callers only pop a non-empty stack
            topPtr <= topPtr - 1'b1;
            count  <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[pushPtr] <= pushAddr;   // Wraps over the oldest when full
        end
    end

    assign peek  = mem[topPtr];
    assign empty = (count == '0);

endmodule

// ==== hw/btb/btbUpdate.sv ====
/*
 * Turns one resolved-branch update into a buffer write, a PLRU touch and
 * a return stack push or pop. Purely combinational, so everything it
 * drives takes effect at the edge where the update is presented.
 */
`include "btb_macros.svh"

module btbUpdate (
    input  logic                  updValid,
    input  btbPkg::updateT        upd,
    input  btbPkg::wayT           victimWay,
    input  logic                  rasEmpty,
    output logic [`BTB_WAYS-1:0]  writeEn,
    output btbPkg::setT           writeSet,
    output btbPkg::btbEntryT      writeEntry,
    output btbPkg::wayT           writeWay,
    output logic                  writeAccess,
    output logic                  rasPush,
    output branchPkg::addrT       rasPushAddr,
    output logic                  rasPop
);

    logic isCall;
    logic isRet;
    logic doWrite;

    // Plain saturating 2-bit step toward the resolved outcome
    function automatic branchPkg::counterT stepCounter(branchPkg::counterT cnt,
                                                        logic taken);
        if (taken) begin
            return (cnt == 2'b11) ? cnt : cnt + 1'b1;
        end
        return (cnt == 2'b00) ? cnt : cnt - 1'b1;
    endfunction

    assign isCall  = (upd.brType == branchPkg::CALL) || (upd.brType == branchPkg::ICALL);
    assign isRet   = (upd.brType == branchPkg::RET);
    assign doWrite = updValid && (upd.brType != branchPkg::NONE);

    // ------------------------------------------------------------
    // Buffer write
    // ------------------------------------------------------------
    assign writeWay    = upd.prevHit ? upd.prevWay : victimWay;   // Refresh in place on a hit
    assign writeSet    = btbPkg::setOf(upd.fetchAddr);
    assign writeAccess = doWrite;

    always_comb begin
        writeEn           = '0;
        writeEn[writeWay] = doWrite;
    end

    always_comb begin
        writeEntry        = '0;
        writeEntry.tag    = btbPkg::tagOf(upd.fetchAddr);
        writeEntry.brType = upd.brType;
        writeEntry.index  = upd.index;
        if (!isRet) begin
            writeEntry.target = upd.target;       // Returns take the stack top instead
        end
        if (upd.brType == branchPkg::COND) begin
            // A fresh entry starts from strongly not taken
            writeEntry.counter = stepCounter(upd.prevHit ? upd.prevCounter : 2'b00,
                                             upd.taken);
        end
    end

    // ------------------------------------------------------------
    // Return stack
    // ------------------------------------------------------------
    // Return address is the halfword after a 4-byte call
    assign rasPushAddr = upd.fetchAddr + branchPkg::addrT'({upd.index, 1'b0})
                       + branchPkg::addrT'(4);
    assign rasPush     = updValid && isCall;
    assign rasPop      = updValid && isRet && !rasEmpty;

endmodule

// ==== hw/microBtb.sv ====
/*
 * Micro BTB top level. Lookup is a two-stage pipeline: the storage read
 * and stage 1 register, then the prediction output register. A request
 * accepted at edge N is presented with predValid sampled high at N+2.
 * One update port trains the buffer and the return stack.
 */
`include "btb_macros.svh"

module microBtb (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetchValid,
    input  btbPkg::lookupReqT   fetchReq,
    output logic                fetchReady,
    output logic                predValid,
    output btbPkg::predictionT  pred,
    input  logic                predReady,
    input  logic                flush,
    input  logic                updValid,
    input  btbPkg::updateT      upd
);

    logic                              stall;
    logic                              s1Valid;
    branchPkg::addrT                   s1Addr;
    branchPkg::addrT                   readAddr;
    btbPkg::setT                       readSet;
    btbPkg::tagT                       readTag;
    logic [`BTB_WAYS-1:0]              hitWay;
    btbPkg::btbEntryT [`BTB_WAYS-1:0]  readEntry;
    logic                              anyHit;
    btbPkg::wayT                       hitIdx;
    btbPkg::btbEntryT                  hitEntry;
    btbPkg::predictionT                s1Pred;
    logic [`BTB_WAYS-1:0]              writeEn;
    btbPkg::setT                       writeSet;
    btbPkg::btbEntryT                  writeEntry;
    btbPkg::wayT                       writeWay;
    logic                              writeAccess;
    btbPkg::wayT                       victimWay;
    logic                              rasPush;
    branchPkg::addrT                   rasPushAddr;
    logic                              rasPop;
    branchPkg::addrT                   rasPeek;
    branchPkg::addrT                   peekOrZero;
    logic                              rasEmpty;

    assign stall      = predValid && !predReady;   // Held prediction not taken yet
    assign fetchReady = !stall;

    // While frozen, keep re-reading the set held in stage 1
    assign readAddr = stall ? s1Addr : fetchReq.fetchAddr;
    assign readSet  = btbPkg::setOf(readAddr);
    assign readTag  = btbPkg::tagOf(readAddr);

    btbWayArray wayArray (
        .clk, .rst, .readSet, .readTag, .writeEn, .writeSet, .writeEntry,
        .hitWay, .readEntry
    );

    plruTree plru (
        .clk, .rst,
        .readAccess  (s1Valid && anyHit && !stall),
        .readSet     (btbPkg::setOf(s1Addr)),
        .readWay     (hitIdx),
        .writeAccess, .writeSet, .writeWay, .victimWay
    );

    returnStack ras (
        .clk, .rst, .push(rasPush), .pushAddr(rasPushAddr), .pop(rasPop),
        .peek(rasPeek), .empty(rasEmpty)
    );

    btbUpdate updater (
        .updValid, .upd, .victimWay, .rasEmpty, .writeEn, .writeSet,
        .writeEntry, .writeWay, .writeAccess, .rasPush, .rasPushAddr, .rasPop
    );

    // ------------------------------------------------------------
    // Stage 1: way select and prediction rules
    // ------------------------------------------------------------
    always_comb begin
        hitIdx = '0;
        for (int w = 0; w < `BTB_WAYS; w++) begin
            if (hitWay[w]) begin
                hitIdx = btbPkg::wayT'(w);
            end
        end
    end

    assign anyHit     = |hitWay;
    assign hitEntry   = readEntry[hitIdx];
    assign peekOrZero = rasEmpty ? '0 : rasPeek;

    always_comb begin
        s1Pred         = '0;               // Miss: NONE, not taken, target 0
        s1Pred.rasPeek = peekOrZero;
        if (anyHit) begin
            s1Pred.hit     = 1'b1;
            s1Pred.way     = hitIdx;
            s1Pred.brType  = hitEntry.brType;
            s1Pred.index   = hitEntry.index;
            s1Pred.counter = hitEntry.counter;
            s1Pred.target  = hitEntry.target;
            case (hitEntry.brType)
                branchPkg::JMP, branchPkg::IJMP,
                branchPkg::CALL, branchPkg::ICALL: s1Pred.taken = 1'b1;
                branchPkg::COND: s1Pred.taken = hitEntry.counter[1];
                branchPkg::RET: begin
                    s1Pred.taken  = !rasEmpty;
                    s1Pred.target = peekOrZero;
                end
                default: s1Pred.taken = 1'b0;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1Valid   <= 1'b0;
            predValid <= 1'b0;
        end else if (!stall) begin
            s1Valid   <= fetchValid;
            predValid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1Addr <= fetchReq.fetchAddr;
            pred   <= s1Pred;       // Holds steady under back-pressure
        end
    end

endmodule

// ==== test/clockGen.sv ====
/*
 * Free-running testbench clock, 40 ns period by default.
 */
module clockGen #(
    parameter int HALF_NS = 20
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;

endmodule

// ==== test/microBtb_checker.sv ====
/*
 * Concurrent assertions on the micro BTB handshake and prediction rules.
 * Attached to every microBtb instance by the bind at the bottom.
 */
module microBtb_checker (
    input logic               clk,
    input logic               rst,
    input logic               fetchReady,
    input logic               predValid,
    input logic               predReady,
    input btbPkg::predictionT pred
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;   // Number of failed assertions

    // Output register comes out of reset empty
    assert property (@(posedge clk) rst |=> !predValid)
        else begin
            failCount++;
            $error("predValid set in the cycle after reset");
        end

    // A held prediction must not change until it is taken
    assert property (@(posedge clk) disable iff (rst)
        (predValid && !predReady) |=> $stable(pred))
        else begin
            failCount++;
            $error("pred changed while waiting for predReady");
        end

    assert property (@(posedge clk) disable iff (rst)
        (predValid && pred.brType == branchPkg::NONE) |-> !pred.taken)
        else begin
            failCount++;
            $error("prediction of type NONE marked taken");
        end

    assert property (@(posedge clk) disable iff (rst)
        !fetchReady |-> (predValid && !predReady))
        else begin
            failCount++;
            $error("fetchReady low without a held prediction");
        end

endmodule

bind microBtb microBtb_checker rulesCheck (.*);

// ==== test/microBtb_tb.sv ====
/*
 * Directed testbench for the micro BTB. Trains the buffer and the return
 * stack through the update port, then checks lookups against the rules
 * for hits, counters, returns, replacement, back-pressure and flush.
 */
module microBtb_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS     = 40;
    localparam int PRED_WAIT  = 20;    // Cycles a single lookup may take
    localparam int STREAM_LEN = 24;
    // Cycle estimates per test, in run order
    localparam int TEST_CYCLES = 12 + 75 + 25 + 35 + (2 * STREAM_LEN + 12) + 7 + 13;
    localparam int WATCHDOG_NS = (2 * TEST_CYCLES + 4) * CLK_NS;   // 2x margin

    logic               clk;
    logic               rst;
    logic               fetchValid;
    logic               fetchReady;
    logic               predValid;
    logic               predReady;
    logic               flush;
    logic               updValid;
    btbPkg::lookupReqT  fetchReq;
    btbPkg::predictionT pred;
    btbPkg::updateT     upd;
    int                 checks = 0;
    int                 valueErrors = 0;
    int                 otherErrors = 0;
    int                 assertErrors = 0;

    clockGen #(.HALF_NS(CLK_NS / 2)) clkGen (.clk);

    microBtb microBtb_inst (.*);

    // ------------------------------------------------------------
    // Compare tasks, one per result type
    // ------------------------------------------------------------
    task automatic noteResult(string name, logic mismatch, logic [63:0] got,
                              logic [63:0] exp);
        checks++;
        if (mismatch) begin
            valueErrors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compareAddr(string name, branchPkg::addrT got, branchPkg::addrT exp);
        noteResult(name, got !== exp, 64'(got), 64'(exp));
    endtask

    task automatic compareType(string name, branchPkg::branchTypeT got,
                               branchPkg::branchTypeT exp);
        noteResult(name, got !== exp, 64'(got), 64'(exp));
    endtask

    task automatic compareCounter(string name, branchPkg::counterT got,
                                  branchPkg::counterT exp);
        noteResult(name, got !== exp, 64'(got), 64'(exp));
    endtask

    task automatic compareIndex(string name, branchPkg::hwIndexT got,
                                branchPkg::hwIndexT exp);
        noteResult(name, got !== exp, 64'(got), 64'(exp));
    endtask

    task automatic compareWay(string name, btbPkg::wayT got, btbPkg::wayT exp);
        noteResult(name, got !== exp, 64'(got), 64'(exp));
    endtask

    task automatic compareBit(string name, logic got, logic exp);
        noteResult(name, got !== exp, 64'(got), 64'(exp));
    endtask

    // ------------------------------------------------------------
    // Expected values and stimulus helpers
    // ------------------------------------------------------------
    // Five distinct tags, all in set 5
    function automatic branchPkg::addrT repAddr(int i);
        return 32'h0000_0028 + i * 32'h0001_0000;
    endfunction

    function automatic branchPkg::addrT repTarget(int i);
        return 32'h0000_8000 + i * 32'h0000_0100;
    endfunction

    // Halfword after a 4-byte call at the given slot
    function automatic branchPkg::addrT retAddr(branchPkg::addrT block, int idx);
        return block + 32'(2 * idx + 4);
    endfunction

    function automatic branchPkg::counterT nextCount(branchPkg::counterT c, logic taken);
        int v;
        v = int'(c) + (taken ? 1 : -1);
        if (v < 0) begin
            v = 0;
        end else if (v > 3) begin
            v = 3;
        end
        return branchPkg::counterT'(v);
    endfunction

    function automatic btbPkg::updateT makeUpd(branchPkg::addrT addr,
            branchPkg::hwIndexT idx, branchPkg::branchTypeT t, logic taken,
            branchPkg::addrT target, btbPkg::predictionT prev);
        btbPkg::updateT u;
        u.fetchAddr   = addr;
        u.index       = idx;
        u.brType      = t;
        u.taken       = taken;
        u.target      = target;
        u.prevHit     = prev.hit;      // Carried over from the earlier lookup
        u.prevWay     = prev.way;
        u.prevCounter = prev.counter;
        return u;
    endfunction

    task automatic sendUpdate(btbPkg::updateT u);
        @(posedge clk);
        updValid <= 1'b1;
        upd      <= u;
        @(posedge clk);                // Update lands at this edge
        updValid <= 1'b0;
    endtask

    task automatic lookup(input branchPkg::addrT addr, output btbPkg::predictionT p);
        int waited;
        @(posedge clk);
        fetchValid <= 1'b1;
        fetchReq   <= '{fetchAddr: addr};
        @(negedge clk);
        while (!fetchReady) begin
            @(negedge clk);
        end
        @(posedge clk);                // Request accepted
        fetchValid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!predValid && waited < PRED_WAIT) begin
            waited++;
            @(negedge clk);
        end
        if (!predValid) begin
            otherErrors++;
            $display("No prediction arrived for the lookup of 0x%h", addr);
        end
        p = pred;
        @(posedge clk);                // predReady high, transfers here
    endtask

    task automatic checkPred(btbPkg::predictionT p, logic hit, branchPkg::branchTypeT t,
                             logic taken, branchPkg::addrT target);
        compareBit("pred.hit", p.hit, hit);
        compareType("pred.brType", p.brType, t);
        compareBit("pred.taken", p.taken, taken);
        compareAddr("pred.target", p.target, target);
    endtask

    // Entry i of the replacement set, entry 0 is the evicted one
    task automatic checkRep(btbPkg::predictionT p, int i);
        if (i == 0) begin
            checkPred(p, 1'b0, branchPkg::NONE, 1'b0, 32'h0);
        end else begin
            checkPred(p, 1'b1, branchPkg::JMP, 1'b1, repTarget(i));
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic missAndJump();
        btbPkg::predictionT p;
        lookup(32'h0000_1040, p);
        checkPred(p, 1'b0, branchPkg::NONE, 1'b0, 32'h0);
        sendUpdate(makeUpd(32'h0000_1040, 2'd2, branchPkg::JMP, 1'b1, 32'h0000_2000, p));
        lookup(32'h0000_1040, p);
        checkPred(p, 1'b1, branchPkg::JMP, 1'b1, 32'h0000_2000);
        compareIndex("pred.index", p.index, 2'd2);
    endtask

    task automatic condCounter();
        logic [9:0]         outcomes = 10'b10_0000_1111;   // Up to saturation, down, up
        btbPkg::predictionT p;
        branchPkg::counterT model;
        btbPkg::wayT        firstWay;
        model    = 2'b00;
        firstWay = '0;
        for (int k = 0; k <= 10; k++) begin
            lookup(32'h0000_3008, p);
            compareBit("pred.hit", p.hit, k > 0);
            compareCounter("pred.counter", p.counter, model);
            compareBit("pred.taken", p.taken, model[1]);
            if (k == 1) begin
                firstWay = p.way;
            end else if (k > 1) begin
                compareWay("pred.way", p.way, firstWay);   // Refreshed in place
            end
            if (k < 10) begin
                sendUpdate(makeUpd(32'h0000_3008, 2'd1, branchPkg::COND, outcomes[k],
                                   32'h0000_3100, p));
                model = nextCount(model, outcomes[k]);
            end
        end
    endtask

    task automatic returnStackTest();
        btbPkg::predictionT p;
        branchPkg::addrT    retBlock = 32'h0000_5010;
        sendUpdate(makeUpd(retBlock, 2'd1, branchPkg::RET, 1'b1, 32'h0, '0));
        sendUpdate(makeUpd(32'h0000_6000, 2'd1, branchPkg::CALL, 1'b1, 32'h0000_5000, '0));
        sendUpdate(makeUpd(32'h0000_7008, 2'd3, branchPkg::ICALL, 1'b1, 32'h0000_5000, '0));
        lookup(retBlock, p);
        checkPred(p, 1'b1, branchPkg::RET, 1'b1, retAddr(32'h0000_7008, 3));
        compareAddr("pred.rasPeek", p.rasPeek, retAddr(32'h0000_7008, 3));
        sendUpdate(makeUpd(retBlock, 2'd1, branchPkg::RET, 1'b1, 32'h0, p));
        lookup(retBlock, p);
        checkPred(p, 1'b1, branchPkg::RET, 1'b1, retAddr(32'h0000_6000, 1));
        sendUpdate(makeUpd(retBlock, 2'd1, branchPkg::RET, 1'b1, 32'h0, p));
        lookup(retBlock, p);                               // Stack now empty
        checkPred(p, 1'b1, branchPkg::RET, 1'b0, 32'h0);
        compareAddr("pred.rasPeek", p.rasPeek, 32'h0);
    endtask

    task automatic replacement();
        btbPkg::predictionT p;
        logic [3:0]         usedWays;
        usedWays = '0;
        for (int i = 0; i < 5; i++) begin
            sendUpdate(makeUpd(repAddr(i), 2'd0, branchPkg::JMP, 1'b1, repTarget(i), '0));
        end
        for (int i = 0; i < 5; i++) begin
            lookup(repAddr(i), p);
            checkRep(p, i);
            if (i > 0) begin
                if (usedWays[p.way]) begin
                    otherErrors++;
                    $display("Way %0d holds two of the replacement tags", p.way);
                end
                usedWays[p.way] = 1'b1;
            end
        end
    endtask

    // Random predReady, every prediction must arrive once and in order
    task automatic backPressureStream();
        int sent[$];
        int got;
        fork
            begin
                for (int n = 0; n < STREAM_LEN; n++) begin
                    sent.push_back(int'($urandom_range(4, 0)));
                    fetchValid <= 1'b1;
                    fetchReq   <= '{fetchAddr: repAddr(sent[$])};
                    @(negedge clk);
                    while (!fetchReady) begin
                        @(negedge clk);
                    end
                    @(posedge clk);
                end
                fetchValid <= 1'b0;
            end
            begin
                got = 0;
                while (got < STREAM_LEN) begin
                    @(posedge clk);
                    predReady <= 1'($urandom_range(1, 0));
                    @(negedge clk);
                    if (predValid && predReady) begin
                        checkRep(pred, sent.pop_front());
                        got++;
                    end
                end
                @(posedge clk);
                predReady <= 1'b1;
            end
        join
        @(negedge clk);
        compareBit("predValid", predValid, 1'b0);      // Nothing left over
    endtask

    // Back-to-back requests, each shows up two edges after acceptance
    task automatic latencyCheck();
        int order [4] = '{1, 2, 0, 3};
        for (int k = 0; k < 7; k++) begin
            @(posedge clk);
            fetchValid <= (k < 4);
            if (k < 4) begin
                fetchReq <= '{fetchAddr: repAddr(order[k])};
            end
            @(negedge clk);
            compareBit("fetchReady", fetchReady, 1'b1);
            compareBit("predValid", predValid, k >= 2 && k < 6);
            if (k >= 2 && k < 6) begin
                checkRep(pred, order[k - 2]);
            end
        end
    endtask

    task automatic flushTest();
        btbPkg::predictionT p;
        @(posedge clk);
        predReady  <= 1'b0;
        fetchValid <= 1'b1;
        fetchReq   <= '{fetchAddr: repAddr(1)};
        @(posedge clk);
        fetchReq   <= '{fetchAddr: repAddr(2)};
        @(posedge clk);
        fetchValid <= 1'b0;
        flush      <= 1'b1;
        @(negedge clk);
        compareBit("predValid", predValid, 1'b1);      // First one held, second in stage 1
        @(posedge clk);
        flush     <= 1'b0;
        predReady <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            compareBit("predValid", predValid, 1'b0);
        end
        lookup(repAddr(3), p);
        checkRep(p, 3);
    endtask

    // ------------------------------------------------------------
    // Run
    // ------------------------------------------------------------
    initial begin
        void'($urandom(30194));
        rst        = 1'b1;
        fetchValid = 1'b0;
        fetchReq   = '0;
        predReady  = 1'b1;
        flush      = 1'b0;
        updValid   = 1'b0;
        upd        = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        missAndJump();
        condCounter();
        returnStackTest();
        replacement();
        backPressureStream();
        latencyCheck();
        flushTest();
        assertErrors = microBtb_inst.rulesCheck.failCount;
        $display("Summary: %0d checks, %0d mismatches, %0d other, %0d assertion failures",
                 checks, valueErrors, otherErrors, assertErrors);
        if (valueErrors + otherErrors + assertErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+common
common/branchPkg.sv
common/btbPkg.sv
hw/btb/btbWayArray.sv
hw/btb/plruTree.sv
hw/ras/returnStack.sv
hw/btb/btbUpdate.sv
hw/microBtb.sv
test/clockGen.sv
test/microBtb_checker.sv
test/microBtb_tb.sv

// ==== Makefile ====
# Verilator build and run of the micro BTB testbench

VERILATOR ?= verilator
TOP       ?= microBtb_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Errors found

SOURCES := $(shell grep -v '^+' $(FILELIST)) common/btb_macros.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
